// ==== project.f ====
source/codec_cfg_pkg.sv
source/i2c_req_if.sv
source/volume_ctrl.sv
source/codec_cfg_seq.sv
source/i2c_write_master.sv
source/audio_codec_cfg.sv
tb/codec_i2c_slave.sv
tb/tb_audio_codec_cfg.sv

// ==== Makefile ====
# Verilator build and run for the audio codec configuration testbench

TOOL       = verilator
TOP        = tb_audio_codec_cfg
FILELIST   = project.f
FLAGS      = --binary --timing --assert --timescale 1ns/1ns -j 0
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ns
BUILD_DIR  = obj_dir
LOG        = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "No errors" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb/tb_audio_codec_cfg.sv ====
/* Testbench for the audio codec configuration top level
   Init table order, retry after a refused byte, volume button writes */

`timescale 1ns/1ns

module tb_audio_codec_cfg import codec_cfg_pkg::*; ();

  localparam int          CLK_HZ       = 25_000_000;
  localparam int          BUS_HZ       = 625_000;    // Tick every 10 clocks
  localparam int          WR_TIMEOUT   = 4000;       // Cycles, one transfer is ~1170
  localparam int          QUIET        = 2500;       // No write for this long ends a burst
  localparam int          LONG_TIMEOUT = 60000;
  localparam int unsigned SEED         = 32'hdb9ed400;

  logic       iCLK;
  logic       iRST_N;
  logic       vol_up;
  logic       vol_down;
  logic       refuse;
  logic       i2c_scl;
  logic       i2c_sda_oe;
  logic       init_done;
  logic       ack_pull;
  logic       sda_line;
  int         wr_cnt;
  int         refused_cnt;
  i2c_word_u  wr_word;

  int         seen;        // Writes already checked
  int         n_up;
  int         n_down;
  int         count;
  int         waited;
  logic [3:0] idx;
  logic [6:0] model_vol;   // Reference volume
  logic [6:0] last_vol;
  i2c_word_u  w;

  // Open-drain SDA, released unless someone pulls
  assign sda_line = ~((i2c_sda_oe === 1'b1) | (ack_pull === 1'b1));

  audio_codec_cfg #(.CLK_FREQ(CLK_HZ), .I2C_FREQ(BUS_HZ)) uut (
    .iCLK       (iCLK),
    .iRST_N     (iRST_N),
    .vol_up     (vol_up),
    .vol_down   (vol_down),
    .i2c_sda_in (sda_line),
    .i2c_scl    (i2c_scl),
    .i2c_sda_oe (i2c_sda_oe),
    .init_done  (init_done)
  );

  codec_i2c_slave u_codec (
    .scl         (i2c_scl),
    .sda         (sda_line),
    .refuse      (refuse),
    .ack_pull    (ack_pull),
    .wr_cnt      (wr_cnt),
    .wr_word     (wr_word),
    .refused_cnt (refused_cnt)
  );

  initial begin
    iCLK = 1'b0;
    forever #20 iCLK = ~iCLK;  // 40 ns period
  end

  ////////////////////////////////////////////////////////////////////
  // Checks and waits
  ////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input int exp, input int act);
    assert (exp == act) else begin
      $display("** Error %s: expected %0h, actual %0h", name, exp, act);
      $display("Errors found");
      $fatal(1);
    end
  endtask

  task automatic timeout_fail(input string what);
    $display("Timeout: %s", what);
    $display("Errors found");
    $fatal(1);
  endtask

  // Saturating step, the reference for the volume register
  function automatic logic [6:0] next_volume(input logic [6:0] vol, input logic up);
    if (up)
      return (vol == VOL_MAX) ? vol : vol + 7'd1;
    return (vol == VOL_MIN) ? vol : vol - 7'd1;
  endfunction

  task automatic press_button(input logic up);
    @(posedge iCLK);
    if (up) vol_up <= 1'b1;
    else vol_down <= 1'b1;
    repeat (3) @(posedge iCLK);
    vol_up   <= 1'b0;
    vol_down <= 1'b0;
    repeat (3) @(posedge iCLK);   // Gap between presses
    model_vol = next_volume(model_vol, up);
  endtask

  task automatic wait_write(output i2c_word_u word);
    int cyc;
    cyc = 0;
    while (wr_cnt == seen) begin
      if (cyc == WR_TIMEOUT) timeout_fail("no write reached the codec model");
      @(posedge iCLK);
      cyc++;
    end
    word = wr_word;
    seen++;
  endtask

  // Gathers volume writes until the bus stays quiet
  task automatic collect_volume(input string name, output logic [6:0] last,
                                output int n);
    int idle;
    int cyc;
    idle = 0;
    cyc  = 0;
    n    = 0;
    last = '0;
    while (idle < QUIET) begin
      if (cyc == LONG_TIMEOUT) timeout_fail("volume writes never settled");
      @(posedge iCLK);
      cyc++;
      idle++;
      if (wr_cnt != seen) begin
        check_value({name, " address"}, int'(CODEC_ADDR), int'(wr_word.codec.dev_addr));
        check_value({name, " register"}, int'(HP_VOL_REG), int'(wr_word.codec.reg_addr));
        check_value({name, " flags"}, 3, int'(wr_word.codec.reg_data[8:7]));
        last = wr_word.codec.reg_data[6:0];
        seen++;
        n++;
        idle = 0;
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  initial begin
    void'($urandom(SEED));
    iRST_N    = 1'b0;
    vol_up    = 1'b0;
    vol_down  = 1'b0;
    refuse    = 1'b0;
    seen      = 0;
    model_vol = VOL_RESET;
    repeat (2) @(posedge iCLK);
    check_value("reset scl", 1, int'(i2c_scl));
    check_value("reset sda_oe", 0, int'(i2c_sda_oe));
    check_value("reset init_done", 0, int'(init_done));
    iRST_N <= 1'b1;

    // Init table in order, fourth transfer refused once
    for (int i = 0; i < INIT_LEN; i++) begin
      idx = 4'(i);
      wait_write(w);
      check_value($sformatf("init %0d address", i), int'(CODEC_ADDR), int'(w.flat.dev_addr));
      check_value($sformatf("init %0d word", i), int'(INIT_TABLE[idx]),
                  int'(w.flat.reg_word));
      check_value($sformatf("init_done at write %0d", i), 0, int'(init_done));
      if (i == 0) begin
        repeat (3) press_button(1'b1);  // Held back until the table ends
      end
      if (i == 2) begin
        refuse <= 1'b1;
        waited = 0;
        while (refused_cnt == 0) begin
          if (waited == WR_TIMEOUT) timeout_fail("fourth transfer was never refused");
          @(posedge iCLK);
          waited++;
        end
        refuse <= 1'b0;
      end
    end
    waited = 0;
    while (!init_done) begin
      if (waited == 200) timeout_fail("init_done did not rise");
      @(posedge iCLK);
      waited++;
    end

    // Merged write of the presses made during init
    wait_write(w);
    check_value("init presses register", int'(HP_VOL_REG), int'(w.codec.reg_addr));
    check_value("init presses data", int'({2'b11, model_vol}), int'(w.codec.reg_data));
    collect_volume("init presses extra", last_vol, count);
    check_value("init presses extra writes", 0, count);

    // Random up presses, capped at the top
    n_up = int'($urandom % 4) + 1;
    repeat (n_up) press_button(1'b1);
    collect_volume("volume up", last_vol, count);
    check_value("volume up wrote", 1, int'(count > 0));
    check_value("volume up level", int'(model_vol), int'(last_vol));

    // Down to zero, then one more press
    n_down = int'(model_vol);
    repeat (n_down) press_button(1'b0);
    collect_volume("volume down", last_vol, count);
    check_value("volume down level", 0, int'(last_vol));
    press_button(1'b0);
    collect_volume("volume below zero", last_vol, count);
    check_value("volume below zero writes", 0, count);

    if (wr_cnt == seen) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Codec model holds writes that were never checked");
      $display("Errors found");
      $fatal(1);
    end
  end

endmodule

// ==== tb/codec_i2c_slave.sv ====
/* Behavioral codec model on the I2C bus
   Decodes three-byte writes, acknowledges them, can refuse one transfer */

`timescale 1ns/1ns

module codec_i2c_slave import codec_cfg_pkg::*; (
  input  logic      scl,
  input  logic      sda,          // Wired line level
  input  logic      refuse,       // Refuse first byte of next transfer
  output logic      ack_pull,     // High pulls SDA low
  output int        wr_cnt,       // Acknowledged writes so far
  output i2c_word_u wr_word,      // Last acknowledged write
  output int        refused_cnt
);

  logic        active     = 1'b0;  // Inside start..stop
  logic        refuse_now = 1'b0;
  logic        xfer_bad   = 1'b0;  // This transfer was refused
  logic        pull       = 1'b0;
  logic        scl_q      = 1'b1;
  logic        sda_q      = 1'b1;
  logic [23:0] shreg      = '0;
  i2c_word_u   word_q     = '0;
  int          cnt        = 0;     // SCL rises since start, ack slots included
  int          n_wr       = 0;
  int          n_refused  = 0;

  ////////////////////////////////////////////////////////////////////
  // Bus decoder, one process for all line events
  ////////////////////////////////////////////////////////////////////
  always @(scl or sda) begin
    if (scl === 1'b1 && scl_q === 1'b1 && sda !== sda_q) begin
      if (sda === 1'b0) begin       // Start
        active     = 1'b1;
        cnt        = 0;
        xfer_bad   = 1'b0;
        refuse_now = refuse;
      end else if (active) begin    // Stop
        if (cnt == 28 && !xfer_bad) begin  // 27 bit slots, then the stop rise
          word_q = shreg;          // Seen through the codec view
          n_wr   = n_wr + 1;
        end
        active = 1'b0;
      end
    end else if (active && scl === 1'b1 && scl_q !== 1'b1) begin
      if (cnt < 27 && cnt % 9 != 8)
        shreg = {shreg[22:0], sda};  // Data bit, MSB first
      cnt = cnt + 1;
    end else if (active && scl === 1'b0 && scl_q === 1'b1) begin
      if (cnt % 9 == 8) begin       // Byte complete, ack slot next
        if (cnt == 8 && refuse_now) begin
          xfer_bad  = 1'b1;
          n_refused = n_refused + 1;
        end
        if (!xfer_bad)
          pull <= 1'b1;
      end else begin
        pull <= 1'b0;               // Ack slot over
      end
    end
    scl_q = scl;
    sda_q = sda;
  end

  assign ack_pull    = pull;
  assign wr_cnt      = n_wr;
  assign wr_word     = word_q;
  assign refused_cnt = n_refused;

endmodule

// ==== source/audio_codec_cfg.sv ====
/* Audio codec configuration top level
   Init table writer and headphone volume buttons over an I2C write bus */

`timescale 1ns/1ns

module audio_codec_cfg #(
  parameter int CLK_FREQ = 50_000_000,  // System clock
  parameter int I2C_FREQ = 20_000       // Bus bit rate
) (
  input  logic iCLK,
  input  logic iRST_N,
  input  logic vol_up,
  input  logic vol_down,
  input  logic i2c_sda_in,   // Level on the open-drain SDA line
  output logic i2c_scl,
  output logic i2c_sda_oe,   // Pull SDA low when high
  output logic init_done
);

  logic [6:0] volume;
  logic       vol_change;

  i2c_req_if req_bus ();  // Sequencer to bus master

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////
  volume_ctrl u_vol (
    .iCLK       (iCLK),
    .iRST_N     (iRST_N),
    .vol_up     (vol_up),
    .vol_down   (vol_down),
    .volume     (volume),
    .vol_change (vol_change)
  );

  codec_cfg_seq u_seq (
    .iCLK       (iCLK),
    .iRST_N     (iRST_N),
    .volume     (volume),
    .vol_change (vol_change),
    .init_done  (init_done),
    .req        (req_bus.seq)
  );

  i2c_write_master #(
    .CLK_FREQ (CLK_FREQ),
    .I2C_FREQ (I2C_FREQ)
  ) u_mst (
    .iCLK       (iCLK),
    .iRST_N     (iRST_N),
    .i2c_sda_in (i2c_sda_in),
    .i2c_scl    (i2c_scl),
    .i2c_sda_oe (i2c_sda_oe),
    .req        (req_bus.mst)
  );

endmodule

// ==== source/i2c_write_master.sv ====
/* I2C write master
   Sends one three-byte word per request, samples each acknowledge */

`timescale 1ns/1ns

module i2c_write_master #(
  parameter int CLK_FREQ = 50_000_000,
  parameter int I2C_FREQ = 20_000
) (
  input  logic   iCLK,
  input  logic   iRST_N,
  input  logic   i2c_sda_in,   // Wired SDA level
  output logic   i2c_scl,
  output logic   i2c_sda_oe,   // High pulls SDA low
  i2c_req_if.mst req
);

  // Four ticks per bit
  localparam int TICK_DIV = CLK_FREQ / (4 * I2C_FREQ);
  localparam int DIV_W    = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  // Slot numbers: start, 24 data bits with 3 ack slots, stop
  localparam logic [4:0] SLOT_START = 5'd0;
  localparam logic [4:0] SLOT_ACK0  = 5'd9;
  localparam logic [4:0] SLOT_ACK1  = 5'd18;
  localparam logic [4:0] SLOT_ACK2  = 5'd27;
  localparam logic [4:0] SLOT_STOP  = 5'd28;

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             busy;
  logic [4:0]       slot;
  logic [1:0]       phase;       // Quarter of the current bit
  logic [23:0]      shift;       // Outgoing bits, MSB on the line
  logic             nack_q;
  logic             done_q;
  logic             sda_s1, sda_s2;
  logic             ack_slot;
  logic             scl_nxt, oe_nxt;

  //////////////////////////////////////////////////////////////////////
  // Quarter-bit tick
  //////////////////////////////////////////////////////////////////////
  assign tick = busy & (div_cnt == DIV_W'(TICK_DIV - 1));

  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N)
      div_cnt <= '0;
    else if (!busy || tick)
      div_cnt <= '0;  // Every transfer starts on a fresh count
    else
      div_cnt <= div_cnt + 1'b1;
  end

  // SDA input synchronizer
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      sda_s1 <= 1'b1;
      sda_s2 <= 1'b1;
    end else begin
      sda_s1 <= i2c_sda_in;
      sda_s2 <= sda_s1;
    end
  end

  assign ack_slot = (slot == SLOT_ACK0) | (slot == SLOT_ACK1) | (slot == SLOT_ACK2);

  //////////////////////////////////////////////////////////////////////
  // Bit sequencer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      busy   <= 1'b0;
      slot   <= SLOT_START;
      phase  <= 2'd0;
      nack_q <= 1'b0;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!busy) begin
        if (req.req_valid) begin  // Accept, ready is high while idle
          busy   <= 1'b1;
          slot   <= SLOT_START;
          phase  <= 2'd0;
          nack_q <= 1'b0;
        end
      end else if (tick) begin
        // Middle of SCL high in an ack slot
        if (ack_slot && phase == 2'd1 && sda_s2)
          nack_q <= 1'b1;
        phase <= phase + 2'd1;
        if (phase == 2'd3) begin
          if (slot == SLOT_STOP) begin
            busy   <= 1'b0;
            done_q <= 1'b1;
          end else begin
            slot <= slot + 5'd1;
          end
        end
      end
    end
  end

  // Data shifter, advances after each data bit
  always_ff @(posedge iCLK) begin
    if (!busy && req.req_valid)
      shift <= req.req_word;
    else if (tick && phase == 2'd3 && slot != SLOT_START && slot != SLOT_STOP && !ack_slot)
      shift <= {shift[22:0], 1'b0};
  end

  //////////////////////////////////////////////////////////////////////
  // Line levels per slot and phase
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    scl_nxt = 1'b1;  // Idle, both lines released
    oe_nxt  = 1'b0;
    if (busy) begin
      if (slot == SLOT_START) begin
        scl_nxt = (phase != 2'd3);  // SCL drops in the last quarter
        oe_nxt  = (phase != 2'd0);  // SDA falls while SCL high
      end else if (slot == SLOT_STOP) begin
        scl_nxt = (phase != 2'd0);
        oe_nxt  = (phase < 2'd2);   // SDA rises while SCL high
      end else begin
        scl_nxt = (phase == 2'd1) || (phase == 2'd2);
        oe_nxt  = ack_slot ? 1'b0 : ~shift[23];  // Ack slot released
      end
    end
  end

  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      i2c_scl    <= 1'b1;
      i2c_sda_oe <= 1'b0;
    end else begin
      i2c_scl    <= scl_nxt;
      i2c_sda_oe <= oe_nxt;
    end
  end

  assign req.req_ready = ~busy;
  assign req.done      = done_q;
  assign req.nack      = nack_q;

endmodule

// ==== source/codec_cfg_seq.sv ====
/* Codec configuration sequencer
   Walks the init table, retries refused writes, then sends volume updates */

`timescale 1ns/1ns

module codec_cfg_seq import codec_cfg_pkg::*; (
  input  logic       iCLK,
  input  logic       iRST_N,
  input  logic [6:0] volume,
  input  logic       vol_change,
  output logic       init_done,
  i2c_req_if.seq     req
);

  localparam int             IDX_W    = $clog2(INIT_LEN);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(INIT_LEN - 1);

  // FSM states
  localparam logic [1:0] ST_OFFER   = 2'd0;  // Request on the channel
  localparam logic [1:0] ST_WAIT    = 2'd1;  // Transfer on the bus
  localparam logic [1:0] ST_ADVANCE = 2'd2;  // Pick what goes next

  logic [1:0]       state;
  logic [IDX_W-1:0] init_idx;
  logic             vol_pend;    // Change seen, not yet sent
  logic             valid_q;
  i2c_word_u        word_q;

  logic last_entry, vol_ready, acked, retry;
  logic tab_first, tab_next, vol_send, start_req;

  function automatic i2c_word_u table_word(input logic [IDX_W-1:0] idx);
    i2c_word_u w;
    w.flat.dev_addr = CODEC_ADDR;
    w.flat.reg_word = INIT_TABLE[idx];
    return w;
  endfunction

  function automatic i2c_word_u vol_word(input logic [6:0] vol);
    i2c_word_u w;
    w.codec.dev_addr = CODEC_ADDR;
    w.codec.reg_addr = HP_VOL_REG;
    w.codec.reg_data = {1'b1, 1'b1, vol};  // Both channels, zero cross, level
    return w;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Next request decisions
  //////////////////////////////////////////////////////////////////////
  assign last_entry = (init_idx == LAST_IDX);
  assign vol_ready  = vol_pend | vol_change;          // Latest volume is live
  assign acked      = (state == ST_WAIT) & req.done & ~req.nack;
  assign retry      = (state == ST_WAIT) & req.done & req.nack;

  assign tab_first = (state == ST_ADVANCE) & ~init_done;  // Only after reset
  assign tab_next  = acked & ~init_done & ~last_entry;
  // Volume goes out once the table is through and the bus is free
  assign vol_send  = vol_ready &
                     ((acked & (init_done | last_entry)) |
                      ((state == ST_ADVANCE) & init_done));
  assign start_req = tab_first | tab_next | vol_send | retry;

  //////////////////////////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      state     <= ST_ADVANCE;
      init_idx  <= '0;
      init_done <= 1'b0;
      vol_pend  <= 1'b0;
      valid_q   <= 1'b0;
    end else begin
      if (vol_change) vol_pend <= 1'b1;  // Merges presses while busy
      if (vol_send) vol_pend <= 1'b0;
      if (tab_next) init_idx <= init_idx + 1'b1;
      if (acked && last_entry) init_done <= 1'b1;  // Tenth ack

      case (state)
        ST_OFFER: begin
          if (req.req_ready) begin  // Taken this cycle
            valid_q <= 1'b0;
            state   <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          if (req.done) begin
            if (start_req) begin
              valid_q <= 1'b1;
              state   <= ST_OFFER;
            end else begin
              state <= ST_ADVANCE;
            end
          end
        end
        default: begin
          if (start_req) begin
            valid_q <= 1'b1;
            state   <= ST_OFFER;
          end
        end
      endcase
    end
  end

  // Request word, kept as is on a retry
  always_ff @(posedge iCLK) begin
    if (tab_first)
      word_q <= table_word(init_idx);
    else if (tab_next)
      word_q <= table_word(init_idx + 1'b1);
    else if (vol_send)
      word_q <= vol_word(volume);
  end

  assign req.req_valid = valid_q;
  assign req.req_word  = word_q;

endmodule

// ==== source/volume_ctrl.sv ====
/* Headphone volume control
   Button edge detect and a saturating 7-bit volume register */

`timescale 1ns/1ns

module volume_ctrl import codec_cfg_pkg::*; (
  input  logic       iCLK,
  input  logic       iRST_N,
  input  logic       vol_up,      // Push button, active high
  input  logic       vol_down,
  output logic [6:0] volume,
  output logic       vol_change   // One pulse per real change
);

  logic up_q, up_qq;  // Sample stage, then edge stage
  logic dn_q, dn_qq;
  logic up_rise, dn_rise;

  //////////////////////////////////////////////////////////////////////
  // Button sampling
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      up_q  <= 1'b0;
      up_qq <= 1'b0;
      dn_q  <= 1'b0;
      dn_qq <= 1'b0;
    end else begin
      up_q  <= vol_up;
      up_qq <= up_q;
      dn_q  <= vol_down;
      dn_qq <= dn_q;
    end
  end

  assign up_rise = up_q & ~up_qq;  // Rising edge one cycle after input
  assign dn_rise = dn_q & ~dn_qq;

  //////////////////////////////////////////////////////////////////////
  // Volume register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      volume     <= VOL_RESET;
      vol_change <= 1'b0;
    end else begin
      vol_change <= 1'b0;
      // Up wins over down on a shared edge
      if (up_rise) begin
        if (volume != VOL_MAX) begin
          volume     <= volume + 7'd1;
          vol_change <= 1'b1;
        end
      end else if (dn_rise) begin
        if (volume != VOL_MIN) begin
          volume     <= volume - 7'd1;
          vol_change <= 1'b1;
        end
      end
    end
  end

endmodule

// ==== source/i2c_req_if.sv ====
/* Write request channel from the sequencer to the bus master
   One word per request, completion and acknowledge status back */

`timescale 1ns/1ns

interface i2c_req_if import codec_cfg_pkg::*; ();

  logic      req_valid;  // Sequencer offers a word
  i2c_word_u req_word;   // Held while req_valid is high
  logic      req_ready;  // Master idle
  logic      done;       // Stop finished, single cycle
  logic      nack;       // Some byte not acknowledged, valid with done

  // Request side
  modport seq (
    output req_valid,
    output req_word,
    input  req_ready,
    input  done,
    input  nack
  );

  // Bus master side
  modport mst (
    input  req_valid,
    input  req_word,
    output req_ready,
    output done,
    output nack
  );

endinterface

// ==== source/codec_cfg_pkg.sv ====
/* Codec configuration package
   Bus word layout, device address, init register table and volume limits */

package codec_cfg_pkg;

  //////////////////////////////////////////////////////////////////////
  // One I2C write word, seen two ways
  //////////////////////////////////////////////////////////////////////
  typedef union packed {
    struct packed {
      logic [7:0]  dev_addr;   // Device address byte with write bit
      logic [15:0] reg_word;   // Raw register word as stored in the table
    } flat;
    struct packed {
      logic [7:0]  dev_addr;
      logic [6:0]  reg_addr;   // Codec register number
      logic [8:0]  reg_data;   // Codec register payload
    } codec;
  } i2c_word_u;

  localparam logic [7:0] CODEC_ADDR = 8'h34;  // Codec on the bus, write

  //////////////////////////////////////////////////////////////////////
  // Init table, sent in order after reset
  //////////////////////////////////////////////////////////////////////
  localparam int INIT_LEN = 10;

  localparam logic [0:INIT_LEN-1][15:0] INIT_TABLE = {
    16'h001A,   // Line-in left
    16'h021A,   // Line-in right
    16'h0479,   // Headphone left
    16'h0679,   // Headphone right
    16'h08F8,   // Analog path, DAC selected
    16'h0A06,   // Digital path, de-emphasis
    16'h0C00,   // Power, all on
    16'h0E01,   // Data format
    16'h1009,   // Sample rate control
    16'h1201    // Activate
  };

  // Headphone volume register, both channels
  localparam logic [6:0] HP_VOL_REG = 7'd2;

  localparam logic [6:0] VOL_RESET = 7'h79;
  localparam logic [6:0] VOL_MAX   = 7'h7F;  // +6 dB
  localparam logic [6:0] VOL_MIN   = 7'h00;

endpackage
